// ==== source/adc_capture_config.svh ====
`ifndef ADC_CAPTURE_CONFIG_SVH
`define ADC_CAPTURE_CONFIG_SVH

// --------------------
// Datapath geometry
// --------------------
`define ADC_LANES          4     // Lanes from the dual-channel ADC board
`define ADC_LANE_BITS      14    // 12 data plus 2 info per sample
`define ADC_FRAME_SAMPLES  4     // Samples per lane per sys_clk
`define ADC_DATA_BITS      12
`define ADC_INFO_BITS      2

// Deskew range is 0..7 sample times
`define ADC_DLY_BITS       3
`define ADC_BIT_SEL_BITS   6     // Global bit index over 56 bit lines

// Net phase-step counter width
`define ADC_STEP_CNT_BITS  16

// --------------------
// AXI4-Lite byte offsets
// --------------------
`define ADC_REG_CTRL       4'h0  // Bit 0 rdy, bit 1 step direction
`define ADC_REG_DLY        4'h4  // Bits 13:8 bit index, bits 2:0 delay
`define ADC_REG_STEP       4'h8  // Any write issues one phase step
`define ADC_REG_COUNT      4'hC  // Signed net step count

`endif

// ==== source/adc_capture_pkg.sv ====
`include "adc_capture_config.svh"

package adc_capture_pkg;

    // One lane, index 0 is t0 (oldest sample in the frame)
    typedef logic [`ADC_FRAME_SAMPLES-1:0][`ADC_LANE_BITS-1:0] lane_frame_t;
    typedef lane_frame_t [`ADC_LANES-1:0] adc_frame_t;  // All four lanes

    typedef struct packed {
        logic [`ADC_INFO_BITS-1:0] info;
        logic [`ADC_DATA_BITS-1:0] data;
    } iq_sample_t;

    // I from lanes 0/1, Q from lanes 2/3
    typedef struct packed {
        iq_sample_t [2*`ADC_FRAME_SAMPLES-1:0] i;
        iq_sample_t [2*`ADC_FRAME_SAMPLES-1:0] q;
    } iq_set_t;

    typedef struct packed {
        logic                         load;     // One-cycle strobe
        logic [`ADC_BIT_SEL_BITS-1:0] bit_idx;  // Global bit line
        logic [`ADC_DLY_BITS-1:0]     value;
    } dly_load_t;

    typedef enum logic {
        STEP_DEC = 1'b0,
        STEP_INC = 1'b1
    } step_dir_e;

    typedef struct packed {
        logic      req;
        step_dir_e dir;
    } step_req_t;

    // --------------------
    // AXI4-Lite channels
    // --------------------
    typedef struct packed {
        logic        awvalid;
        logic [3:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic        bready;
        logic        arvalid;
        logic [3:0]  araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    typedef enum logic [3:0] {
        REG_CTRL  = `ADC_REG_CTRL,
        REG_DLY   = `ADC_REG_DLY,
        REG_STEP  = `ADC_REG_STEP,
        REG_COUNT = `ADC_REG_COUNT
    } reg_addr_e;

endpackage

// ==== source/adc_regs.sv ====
`timescale 1ns/1ps
`include "adc_capture_config.svh"

module adc_regs import adc_capture_pkg::*; (
    input  logic                                 sys_clk,
    input  logic                                 rst,
    input  axil_req_t                            axil_req,
    output axil_rsp_t                            axil_rsp,
    input  logic signed [`ADC_STEP_CNT_BITS-1:0] step_count,
    output dly_load_t                            dly_load,
    output step_req_t                            step_req,
    output logic                                 rdy
);

    logic        wr_ready_q;   // Shared awready/wready pulse
    logic        bvalid_q;
    logic        rd_ready_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic        wr_hs;
    logic        rd_hs;
    reg_addr_e   wr_sel;
    reg_addr_e   rd_sel;
    logic [1:0]  ctrl_q;       // [0] rdy, [1] step direction
    logic [31:0] dly_word_q;   // Last DLY word, for readback
    logic [31:0] rd_mux;

    assign wr_sel = reg_addr_e'(axil_req.awaddr);
    assign rd_sel = reg_addr_e'(axil_req.araddr);
    assign wr_hs  = wr_ready_q & axil_req.awvalid & axil_req.wvalid;
    assign rd_hs  = rd_ready_q & axil_req.arvalid;

    // --------------------
    // Write channel
    // --------------------
    always_ff @(posedge sys_clk)
    begin
        if (rst)
        begin
            wr_ready_q <= 1'b0;
            bvalid_q   <= 1'b0;
            ctrl_q     <= '0;
            dly_word_q <= '0;
            dly_load   <= '0;
            step_req   <= '0;
        end
        else
        begin
            // AW and W taken together, never while a response is pending
            wr_ready_q <= axil_req.awvalid && axil_req.wvalid && !wr_ready_q && !bvalid_q;
            if (wr_hs)
                bvalid_q <= 1'b1;
            else if (axil_req.bready)
                bvalid_q <= 1'b0;

            if (wr_hs && wr_sel == REG_CTRL)
                ctrl_q <= axil_req.wdata[1:0];
            if (wr_hs && wr_sel == REG_DLY)
                dly_word_q <= axil_req.wdata;

            // Strobes live for the single cycle after the accept
            dly_load.load    <= wr_hs && (wr_sel == REG_DLY);
            dly_load.bit_idx <= axil_req.wdata[13:8];
            dly_load.value   <= axil_req.wdata[2:0];
            step_req.req     <= wr_hs && (wr_sel == REG_STEP);
            step_req.dir     <= step_dir_e'(ctrl_q[1]);  // Direction as set before this write
        end
    end

    // --------------------
    // Read channel
    // --------------------
    always_comb
    begin
        case (rd_sel)
            REG_CTRL:  rd_mux = {30'd0, ctrl_q};
            REG_DLY:   rd_mux = dly_word_q;
            REG_COUNT: rd_mux = {{(32-`ADC_STEP_CNT_BITS){step_count[`ADC_STEP_CNT_BITS-1]}},
                                 step_count};
            default:   rd_mux = 32'd0;   // STEP is write only, holes read zero
        endcase
    end

    always_ff @(posedge sys_clk)
    begin
        if (rst)
        begin
            rd_ready_q <= 1'b0;
            rvalid_q   <= 1'b0;
        end
        else
        begin
            rd_ready_q <= axil_req.arvalid && !rd_ready_q && !rvalid_q;
            if (rd_hs)
                rvalid_q <= 1'b1;
            else if (axil_req.rready)
                rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk)
    begin
        if (rd_hs)
            rdata_q <= rd_mux;   // Held until the master takes it
    end

    always_comb
    begin
        axil_rsp         = '0;
        axil_rsp.awready = wr_ready_q;
        axil_rsp.wready  = wr_ready_q;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = 2'b00;      // Always OKAY
        axil_rsp.arready = rd_ready_q;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = 2'b00;
    end

    assign rdy = ctrl_q[0];   // Ready to the ADC board

endmodule

// ==== source/bit_deskew.sv ====
`timescale 1ns/1ps
`include "adc_capture_config.svh"

module bit_deskew import adc_capture_pkg::*; #(
    parameter int LANE = 0
) (
    input  logic        sys_clk,
    input  logic        rst,
    input  dly_load_t   dly_load,
    input  lane_frame_t frame_in,
    output lane_frame_t frame_out
);

    localparam int FS = `ADC_FRAME_SAMPLES;
    localparam int LB = `ADC_LANE_BITS;
    // Global bit lines owned by this lane
    localparam logic [`ADC_BIT_SEL_BITS-1:0] IDX_LO = `ADC_BIT_SEL_BITS'(LANE * LB);
    localparam logic [`ADC_BIT_SEL_BITS-1:0] IDX_HI = `ADC_BIT_SEL_BITS'(LANE * LB + LB - 1);

    logic [LB-1:0][`ADC_DLY_BITS-1:0] dly_q;       // One delay per bit line
    lane_frame_t                      prev1_q;     // Frame one cycle back
    lane_frame_t                      prev2_q;     // Frame two cycles back
    logic [3*FS-1:0][LB-1:0]          taps;        // Oldest sample at index 0
    lane_frame_t                      aligned;
    logic                             in_range;
    logic [`ADC_BIT_SEL_BITS-1:0]     local_idx;

    assign in_range  = (dly_load.bit_idx >= IDX_LO) && (dly_load.bit_idx <= IDX_HI);
    assign local_idx = dly_load.bit_idx - IDX_LO;

    // --------------------
    // Delay demux
    // --------------------
    always_ff @(posedge sys_clk)
    begin
        if (rst)
            dly_q <= '0;
        else if (dly_load.load && in_range)
            dly_q[local_idx] <= dly_load.value;
    end

    // Sample stream per bit: prev2 t0..t3, prev1 t0..t3, current t0..t3
    assign taps = {frame_in, prev1_q, prev2_q};

    always_comb
    begin
        int pos;
        for (int b = 0; b < LB; b++)
        begin
            for (int s = 0; s < FS; s++)
            begin
                pos = s + 2*FS - int'(dly_q[b]);   // Never below 1 with 3-bit delay
                aligned[s][b] = taps[pos][b];
            end
        end
    end

    always_ff @(posedge sys_clk)
    begin
        if (rst)
        begin
            prev1_q   <= '0;
            prev2_q   <= '0;
            frame_out <= '0;
        end
        else
        begin
            prev2_q   <= prev1_q;
            prev1_q   <= frame_in;
            frame_out <= aligned;   // First pipeline stage
        end
    end

endmodule

// ==== source/phase_step_ctrl.sv ====
`timescale 1ns/1ps
`include "adc_capture_config.svh"

module phase_step_ctrl import adc_capture_pkg::*; (
    input  logic                                 sys_clk,
    input  logic                                 rst,
    input  step_req_t                            step_req,
    output logic                                 step_pulse,
    output step_dir_e                            step_dir,
    output logic signed [`ADC_STEP_CNT_BITS-1:0] step_count
);

    localparam logic signed [`ADC_STEP_CNT_BITS-1:0] CNT_MAX =
        {1'b0, {(`ADC_STEP_CNT_BITS-1){1'b1}}};
    localparam logic signed [`ADC_STEP_CNT_BITS-1:0] CNT_MIN =
        {1'b1, {(`ADC_STEP_CNT_BITS-1){1'b0}}};
    localparam logic signed [`ADC_STEP_CNT_BITS-1:0] CNT_ONE =
        {{(`ADC_STEP_CNT_BITS-1){1'b0}}, 1'b1};   // Plus one at full width

    logic at_max;
    logic at_min;

    assign at_max = (step_count == CNT_MAX);
    assign at_min = (step_count == CNT_MIN);

    // --------------------
    // Pulse and direction
    // --------------------
    always_ff @(posedge sys_clk)
    begin
        if (rst)
        begin
            step_pulse <= 1'b0;
            step_dir   <= STEP_DEC;
        end
        else
        begin
            step_pulse <= step_req.req;    // Request is already one cycle wide
            if (step_req.req)
                step_dir <= step_req.dir;  // Held steady through the pulse and after
        end
    end

    // Net count moves on the same edge the pulse rises
    always_ff @(posedge sys_clk)
    begin
        if (rst)
            step_count <= '0;
        else if (step_req.req)
        begin
            if (step_req.dir == STEP_INC && !at_max)
                step_count <= step_count + CNT_ONE;
            else if (step_req.dir == STEP_DEC && !at_min)
                step_count <= step_count - CNT_ONE;
        end
    end

endmodule

// ==== source/sample_unpack.sv ====
`timescale 1ns/1ps
`include "adc_capture_config.svh"

module sample_unpack import adc_capture_pkg::*; (
    input  logic       sys_clk,
    input  logic       rst,
    input  adc_frame_t frame_in,
    input  logic       valid_in,
    input  logic       sync_in,
    output iq_set_t    iq_out,
    output logic       valid_out,
    output logic       sync_out
);

    localparam int FS = `ADC_FRAME_SAMPLES;

    iq_set_t iq_next;
    logic    valid_d1;   // Stage matching the deskew register
    logic    sync_d1;

    // --------------------
    // Lane to I/Q map
    // --------------------
    always_comb
    begin
        for (int s = 0; s < FS; s++)
        begin
            iq_next.i[s].data      = frame_in[0][s][`ADC_DATA_BITS-1:0];
            iq_next.i[s].info      = frame_in[0][s][`ADC_LANE_BITS-1:`ADC_DATA_BITS];
            iq_next.i[FS+s].data   = frame_in[1][s][`ADC_DATA_BITS-1:0];
            iq_next.i[FS+s].info   = frame_in[1][s][`ADC_LANE_BITS-1:`ADC_DATA_BITS];
            iq_next.q[s].data      = frame_in[2][s][`ADC_DATA_BITS-1:0];
            iq_next.q[s].info      = frame_in[2][s][`ADC_LANE_BITS-1:`ADC_DATA_BITS];
            iq_next.q[FS+s].data   = frame_in[3][s][`ADC_DATA_BITS-1:0];
            iq_next.q[FS+s].info   = frame_in[3][s][`ADC_LANE_BITS-1:`ADC_DATA_BITS];
        end
    end

    // Recapture, second pipeline stage
    always_ff @(posedge sys_clk)
    begin
        if (rst)
        begin
            iq_out    <= '0;
            valid_d1  <= 1'b0;
            sync_d1   <= 1'b0;
            valid_out <= 1'b0;
            sync_out  <= 1'b0;
        end
        else
        begin
            iq_out    <= iq_next;
            valid_d1  <= valid_in;
            sync_d1   <= sync_in;
            valid_out <= valid_d1;   // Two stages total, same as the data
            sync_out  <= sync_d1;
        end
    end

endmodule

// ==== source/adc_capture_top.sv ====
`timescale 1ns/1ps
`include "adc_capture_config.svh"

module adc_capture_top import adc_capture_pkg::*; (
    input  logic       sys_clk,
    input  logic       rst,
    input  axil_req_t  axil_req,
    output axil_rsp_t  axil_rsp,
    input  adc_frame_t adc_in,      // Lane 2 still in board pin order
    input  logic       adc_valid,
    input  logic       adc_sync,
    output iq_set_t    iq_out,
    output logic       iq_valid,
    output logic       iq_sync,
    output logic       rdy,
    output logic       step_pulse,
    output step_dir_e  step_dir
);

    adc_frame_t                           adc_fixed;   // Lane 2 back in bit order
    adc_frame_t                           deskewed;
    dly_load_t                            dly_load;
    step_req_t                            step_req;
    logic signed [`ADC_STEP_CNT_BITS-1:0] step_count;

    // --------------------
    // Lane 2 pin remap
    // --------------------
    assign adc_fixed[0] = adc_in[0];
    assign adc_fixed[1] = adc_in[1];
    assign adc_fixed[3] = adc_in[3];

    for (genvar s = 0; s < `ADC_FRAME_SAMPLES; s++)
    begin : g_lane2_remap
        wire [5:0] z0 = adc_in[2][s][5:0];    // z0 pin group
        wire [5:0] z1 = adc_in[2][s][11:6];   // z1 pin group
        assign adc_fixed[2][s] = {adc_in[2][s][13:12],              // Info is not scrambled
                                  z0[5], z0[4], z1[5], z0[3], z0[2], z1[4],
                                  z0[1], z0[0], z1[3], z1[2], z1[1], z1[0]};
    end

    adc_regs u_regs (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .step_count (step_count),
        .dly_load   (dly_load),
        .step_req   (step_req),
        .rdy        (rdy)
    );

    // One deskew per lane, each owns 14 global bit indices
    bit_deskew #(.LANE(0)) u_lane0 (
        .sys_clk (sys_clk), .rst (rst), .dly_load (dly_load),
        .frame_in (adc_fixed[0]), .frame_out (deskewed[0])
    );
    bit_deskew #(.LANE(1)) u_lane1 (
        .sys_clk (sys_clk), .rst (rst), .dly_load (dly_load),
        .frame_in (adc_fixed[1]), .frame_out (deskewed[1])
    );
    bit_deskew #(.LANE(2)) u_lane2 (
        .sys_clk (sys_clk), .rst (rst), .dly_load (dly_load),
        .frame_in (adc_fixed[2]), .frame_out (deskewed[2])
    );
    bit_deskew #(.LANE(3)) u_lane3 (
        .sys_clk (sys_clk), .rst (rst), .dly_load (dly_load),
        .frame_in (adc_fixed[3]), .frame_out (deskewed[3])
    );

    phase_step_ctrl u_step (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .step_req   (step_req),
        .step_pulse (step_pulse),
        .step_dir   (step_dir),
        .step_count (step_count)
    );

    // Valid and sync go in raw, unpack matches the two-stage latency
    sample_unpack u_unpack (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .frame_in  (deskewed),
        .valid_in  (adc_valid),
        .sync_in   (adc_sync),
        .iq_out    (iq_out),
        .valid_out (iq_valid),
        .sync_out  (iq_sync)
    );

endmodule

// ==== bench/tb_adc_capture.sv ====
`timescale 1ns/1ps

module tb_adc_capture import adc_capture_pkg::*; ();

    localparam int WAIT_LIMIT = 50;    // Cycles allowed for any single handshake

    logic       sys_clk;
    logic       rst;
    axil_req_t  axil_req;
    axil_rsp_t  axil_rsp;
    adc_frame_t adc_in;
    logic       adc_valid;
    logic       adc_sync;
    iq_set_t    iq_out;
    logic       iq_valid;
    logic       iq_sync;
    logic       rdy;
    logic       step_pulse;
    step_dir_e  step_dir;

    // Two-slot queue of expected I/Q sets, matching the datapath latency
    iq_set_t    pend1, pend2;
    logic [1:0] pend1_vs, pend2_vs;
    logic       pend1_v, pend2_v;

    int          errors, checks, tests, test_errs, fd, code;
    logic        timed_out;
    logic        open_err;
    string       op, op2, test_name, line;
    logic [3:0]  addr;
    logic [31:0] wr_data, wr_data2, exp_data, rd_data, tmp;

    adc_capture_top u_dut (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .adc_in     (adc_in),
        .adc_valid  (adc_valid),
        .adc_sync   (adc_sync),
        .iq_out     (iq_out),
        .iq_valid   (iq_valid),
        .iq_sync    (iq_sync),
        .rdy        (rdy),
        .step_pulse (step_pulse),
        .step_dir   (step_dir)
    );

    always #20 sys_clk = ~sys_clk;   // 40 ns period

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_iq(input iq_set_t got, input iq_set_t exp,
                            input logic [1:0] got_vs, input logic [1:0] exp_vs);
        checks++;
        if (got !== exp || got_vs !== exp_vs)
        begin
            errors++;
            test_errs++;
            $display("ERR %0t: iq set %h v/s %b, expected %h v/s %b",
                     $time, got, got_vs, exp, exp_vs);
        end
    endtask

    task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            test_errs++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_step(input step_dir_e got_dir, input logic got_pulse,
                              input step_dir_e exp_dir, input logic exp_pulse);
        checks++;
        if (got_dir !== exp_dir || got_pulse !== exp_pulse)
        begin
            errors++;
            test_errs++;
            $display("ERR %0t: step dir %0d pulse %b, expected dir %0d pulse %b",
                     $time, got_dir, got_pulse, exp_dir, exp_pulse);
        end
    endtask

    // One clock, sampled and driven 2 ns after the edge
    task automatic tick();
        @(posedge sys_clk);
        #2;
        if (pend2_v)
            check_iq(iq_out, pend2, {iq_valid, iq_sync}, pend2_vs);
        pend2    = pend1;
        pend2_vs = pend1_vs;
        pend2_v  = pend1_v;
        pend1_v  = 1'b0;
        adc_in    = '0;   // Idle frames between frame blocks
        adc_valid = 1'b0;
        adc_sync  = 1'b0;
    endtask

    function automatic logic rsp_flag(input string name);
        case (name)
            "awready":    return axil_rsp.awready;
            "bvalid":     return axil_rsp.bvalid;
            "arready":    return axil_rsp.arready;
            "rvalid":     return axil_rsp.rvalid;
            "step_pulse": return step_pulse;
            default:      return 1'b0;
        endcase
    endfunction

    task automatic wait_for(input string name);
        int n;
        n = 0;
        while (!rsp_flag(name) && n < WAIT_LIMIT && !timed_out)
        begin
            tick();
            n++;
        end
        if (!rsp_flag(name) && !timed_out)
        begin
            timed_out = 1'b1;
            $display("Timed out at %0t waiting for %s", $time, name);
        end
    endtask

    // --------------------
    // AXI4-Lite master
    // --------------------
    task automatic axi_write(input logic [3:0] a, input logic [31:0] d);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = a;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = d;
        wait_for("awready");
        if (!timed_out)
            check_reg({31'd0, axil_rsp.wready}, 32'd1, "wready");   // W taken with AW
        tick();                      // Handshake edge
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        wait_for("bvalid");
        if (!timed_out)
            check_reg({30'd0, axil_rsp.bresp}, 32'd0, "bresp");
        if (axil_req.bready)
            tick();                  // Response taken on this edge
    endtask

    task automatic axi_read(input logic [3:0] a, output logic [31:0] d);
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = a;
        wait_for("arready");
        tick();
        axil_req.arvalid = 1'b0;
        wait_for("rvalid");
        if (!timed_out)
            check_reg({30'd0, axil_rsp.rresp}, 32'd0, "rresp");
        d = axil_rsp.rdata;
    endtask

    task automatic step_test(input step_dir_e dir);
        axi_write(REG_STEP, 32'd0);
        wait_for("step_pulse");
        check_step(step_dir, step_pulse, dir, 1'b1);
        tick();
        check_step(step_dir, step_pulse, dir, 1'b0);   // Exactly one cycle wide
    endtask

    // First write left unanswered, second must stall behind it
    task automatic back_pressure(input logic [3:0] a, input logic [31:0] d1,
                                 input logic [31:0] d2);
        axil_req.bready = 1'b0;
        axi_write(a, d1);
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = d2;
        repeat (5)
        begin
            tick();
            check_reg({31'd0, axil_rsp.bvalid}, 32'd1, "bvalid under back-pressure");
            check_reg({31'd0, axil_rsp.awready}, 32'd0, "awready under back-pressure");
        end
        axil_req.bready = 1'b1;
        wait_for("awready");
        tick();
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        wait_for("bvalid");
    endtask

    // F line then E line, expected set checked two cycles on
    task automatic frame_pair();
        adc_frame_t  f_in;
        iq_set_t     f_exp;
        logic [31:0] v, s, ev, es, w;
        code = $fscanf(fd, " %h %h", v, s);
        for (int k = 0; k < 16; k++)
        begin
            code = $fscanf(fd, " %h", w);
            f_in[k/4][k%4] = w[13:0];
        end
        code = $fscanf(fd, " %s %h %h", op2, ev, es);
        if (op2 != "E")
        begin
            errors++;
            $display("Frame line is not followed by an expected line");
        end
        for (int k = 0; k < 16; k++)
        begin
            code = $fscanf(fd, " %h", w);
            if (k < 8)
                f_exp.i[k] = w[13:0];
            else
                f_exp.q[k-8] = w[13:0];
        end
        tick();
        adc_in    = f_in;
        adc_valid = v[0];
        adc_sync  = s[0];
        pend1     = f_exp;
        pend1_vs  = {ev[0], es[0]};
        pend1_v   = 1'b1;
    endtask

    task automatic finish_test();
        if (tests > 0)
            $display("test %s done, %0d errors", test_name, test_errs);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial
    begin
        sys_clk   = 1'b0;
        rst       = 1'b1;
        axil_req  = '0;
        axil_req.bready = 1'b1;
        axil_req.rready = 1'b1;
        adc_in    = '0;
        adc_valid = 1'b0;
        adc_sync  = 1'b0;
        pend1_v   = 1'b0;
        pend2_v   = 1'b0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        test_errs = 0;
        timed_out = 1'b0;
        open_err  = 1'b0;
        fd = $fopen("bench/adc_capture_golden.txt", "r");
        if (fd == 0)
        begin
            open_err = 1'b1;
            $display("Could not open the golden data file");
        end
        repeat (10) @(posedge sys_clk);
        #2;
        rst = 1'b0;
        while (!open_err && !timed_out && $fscanf(fd, " %s", op) == 1)
        begin
            case (op)
                "#": code = $fgets(line, fd);           // Comment line
                "T":
                begin
                    finish_test();
                    code = $fscanf(fd, " %s", test_name);
                    test_errs = 0;
                    tests++;
                end
                "Z":
                begin
                    check_iq(iq_out, '0, {iq_valid, iq_sync}, 2'b00);
                    check_reg({31'd0, rdy}, 32'd0, "rdy");
                    check_step(step_dir, step_pulse, STEP_DEC, 1'b0);
                end
                "W":
                begin
                    code = $fscanf(fd, " %h %h", addr, wr_data);
                    axi_write(addr, wr_data);
                end
                "R":
                begin
                    code = $fscanf(fd, " %h %h", addr, exp_data);
                    axi_read(addr, rd_data);
                    check_reg(rd_data, exp_data, "read data");
                end
                "Y":
                begin
                    code = $fscanf(fd, " %h", tmp);
                    check_reg({31'd0, rdy}, tmp, "rdy");
                end
                "S":
                begin
                    code = $fscanf(fd, " %h", tmp);
                    step_test(step_dir_e'(tmp[0]));
                end
                "B":
                begin
                    code = $fscanf(fd, " %h %h %h", addr, wr_data, wr_data2);
                    back_pressure(addr, wr_data, wr_data2);
                end
                "F": frame_pair();
                default:
                begin
                    errors++;
                    $display("Unknown golden line type %s", op);
                end
            endcase
        end
        if (!timed_out)
        begin
            tick();   // Drain the last two expected sets
            tick();
        end
        finish_test();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out && !open_err)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== bench/adc_capture_golden.txt ====
# T name | Z reset check | W addr data | R addr expected | Y rdy | S dir | B addr data1 data2
# F valid sync + 16 words I0..I7 Q0..Q7 (lane 2 in pin order), E same layout with expected words
T reset
Z
R 0 00000000
R c 00000000
T zero_delay
F 1 1 0001 0002 0003 0004 0010 0020 0030 0040 003f 0fc0 3000 0001 1fff 2aaa 1555 0000
E 1 1 0001 0002 0003 0004 0010 0020 0030 0040 0db0 024f 3000 0010 1fff 2aaa 1555 0000
F 1 0 0100 0200 0300 0400 1000 2000 3000 0fff 0040 0020 0800 1fff 0123 0456 0789 0abc
E 1 0 0100 0200 0300 0400 1000 2000 3000 0fff 0001 0800 0200 1fff 0123 0456 0789 0abc
F 0 0 2aaa 2aaa 2aaa 2aaa 2aaa 2aaa 2aaa 2aaa 2aaa 2aaa 2aaa 2aaa 2aaa 2aaa 2aaa 2aaa
E 0 0 2aaa 2aaa 2aaa 2aaa 2aaa 2aaa 2aaa 2aaa 2b2a 2b2a 2b2a 2b2a 2aaa 2aaa 2aaa 2aaa
T bit_delay
W 4 00000001
W 4 00001304
W 4 00001e03
W 4 00003707
R 4 00003707
F 1 0 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff
E 1 0 3ffe 3fff 3fff 3fff 3fdf 3fdf 3fdf 3fdf 3ffb 3ffb 3ffb 3fff 1fff 1fff 1fff 1fff
F 1 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
E 1 0 0001 0000 0000 0000 0020 0020 0020 0020 0004 0004 0004 0000 0000 0000 0000 2000
F 1 0 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff 3fff
E 1 0 3ffe 3fff 3fff 3fff 3fdf 3fdf 3fdf 3fdf 3ffb 3ffb 3ffb 3fff 3fff 3fff 3fff 1fff
T phase_step
W 0 00000003
S 1
S 1
S 1
R c 00000003
W 0 00000001
S 0
S 0
S 0
S 0
R c ffffffff
T control
W 0 00000001
Y 1
R 0 00000001
R 2 00000000
W 0 00000000
Y 0
B 0 00000003 00000001
R 0 00000001
Y 1

// ==== compile.f ====
+incdir+source
source/adc_capture_pkg.sv
source/adc_regs.sv
source/bit_deskew.sv
source/phase_step_ctrl.sv
source/sample_unpack.sv
source/adc_capture_top.sv
bench/tb_adc_capture.sv

// ==== Makefile ====
TB_TOP  := tb_adc_capture
RTL_TOP := adc_capture_top

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -f compile.f --top-module $(RTL_TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TB_TOP) -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1; cat sim.log
	grep -q "^TESTBENCH PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
